// ==== hdl/regfile_config.svh ====
/*
 * Build-time settings for the register file: machine identity values,
 * the ISA extension word and the performance-counter enable.
 * Included by the control-register bank and the testbench.
 */
`ifndef REGFILE_CONFIG_SVH
`define REGFILE_CONFIG_SVH

// Machine identity registers, read-only
`define REGFILE_VENDORID 32'h0000_0000
`define REGFILE_ARCHID 32'h0000_0000
`define REGFILE_IMPID 32'h0001_0002
`define REGFILE_HARTID 32'h0000_0000

// Extension bits of misa, 30 bits wide
// Bit 8 is the base integer ISA
`define REGFILE_ISA 30'h0000_0100

// Zero makes all counter halves read as zero
`define REGFILE_ENABLE_COUNTERS 1

`endif

// ==== hdl/regfile_pkg.sv ====
/*
 * Shared types of the register file and the indices of the machine
 * control registers within the upper half of the register address space.
 */
package regfile_pkg;

	// One data word of the core
	typedef logic [31:0] word_t;

	// Register address, bit 5 set selects a control register
	typedef logic [5:0] reg_addr_t;

	// Control-register index, low five bits of a control address
	typedef logic [4:0] csr_index_t;

	// Status and trap setup
	localparam csr_index_t csr_mstatus = 5'd0;
	localparam csr_index_t csr_misa = 5'd1;
	localparam csr_index_t csr_mie = 5'd2;
	localparam csr_index_t csr_mtvec = 5'd3;

	// Trap handling
	localparam csr_index_t csr_mscratch = 5'd4;
	localparam csr_index_t csr_mcause = 5'd5;
	localparam csr_index_t csr_mip = 5'd6;

	// 64-bit counters, low and high halves
	localparam csr_index_t csr_mcycle = 5'd7;
	localparam csr_index_t csr_mcycleh = 5'd8;
	localparam csr_index_t csr_minstret = 5'd9;
	localparam csr_index_t csr_minstreth = 5'd10;

	// Identity, read-only
	localparam csr_index_t csr_mvendorid = 5'd11;
	localparam csr_index_t csr_marchid = 5'd12;
	localparam csr_index_t csr_mimpid = 5'd13;
	localparam csr_index_t csr_mhartid = 5'd14;

	// Writing here requests a soft reset of the core
	localparam csr_index_t csr_soft_reset = 5'd15;

endpackage

// ==== hdl/reg_access_if.sv ====
/*
 * Access bundle shared by the two register banks: one write port and
 * two read addresses, all valid in every cycle.
 */
`timescale 1ns/1ns

interface reg_access_if;
	import regfile_pkg::*;

	// Write port
	logic wen;
	reg_addr_t waddr;
	word_t wdata;

	// Read addresses for ports A and B
	reg_addr_t ra_addr;
	reg_addr_t rb_addr;

	// Driven from the top-level input ports
	modport source (
		output wen, waddr, wdata, ra_addr, rb_addr
	);

	// Seen by each bank, which decodes its own address class
	modport bank (
		input wen, waddr, wdata, ra_addr, rb_addr
	);

endinterface

// ==== hdl/gpr_bank.sv ====
/*
 * General register bank: registers 1 to 31 with one write port and two
 * registered read ports. Register 0 is not stored.
 */
`timescale 1ns/1ns

module gpr_bank (
	input logic clock,
	reg_access_if.bank access,
	output regfile_pkg::word_t ra_gpr,
	output regfile_pkg::word_t rb_gpr
);
	import regfile_pkg::*;

	// Storage for x1 to x31
	word_t regs [31:1];

	logic wr_gpr;

	// General class with a nonzero index
	assign wr_gpr = access.wen && !access.waddr[5] && (access.waddr[4:0] != 5'd0);

	always_ff @(posedge clock) begin
		if (wr_gpr) begin
			regs[access.waddr[4:0]] <= access.wdata;
		end
	end

	/*
	 * Read data is registered on the same edge as any write, so a read
	 * in the write cycle sees the old contents. Index 0 and control
	 * addresses produce don't-care data, replaced later in read_select.
	 */
	always_ff @(posedge clock) begin
		ra_gpr <= regs[access.ra_addr[4:0]];
		rb_gpr <= regs[access.rb_addr[4:0]];
	end

endmodule

// ==== hdl/csr_bank.sv ====
/*
 * Machine control registers: cycle and retired-instruction counters,
 * trap setup and status, identity registers and the soft-reset request.
 * Both read ports are registered, one cycle from address to data.
 */
`timescale 1ns/1ns

`include "regfile_config.svh"

module csr_bank (
	input logic clock,
	input logic reset,
	reg_access_if.bank access,
	input logic instr_complete,
	input logic trap,
	input logic tret,
	input logic irq,
	output regfile_pkg::word_t ra_csr,
	output regfile_pkg::word_t rb_csr,
	output logic soft_reset_req,
	output regfile_pkg::word_t mtvec,
	output logic meie,
	output logic mie
);
	import regfile_pkg::*;

	localparam bit counters_on = (`REGFILE_ENABLE_COUNTERS != 0);

	logic [63:0] cycle_count;
	logic [63:0] instr_count;
	word_t mscratch;
	logic mcause_int;
	logic [3:0] mcause_code;

	// Saved interrupt enable
	logic mpie;

	logic wr_csr;
	csr_index_t wr_index;

	assign wr_csr = access.wen && access.waddr[5];
	assign wr_index = access.waddr[4:0];

	// Combinational, follows wen in the same cycle
	assign soft_reset_req = wr_csr && (wr_index == csr_soft_reset);

	// Counters, a half write replaces the increment at that edge
	always_ff @(posedge clock) begin
		if (reset) begin
			cycle_count <= 64'd0;
			instr_count <= 64'd0;
		end else begin
			if (wr_csr && wr_index == csr_mcycle) begin
				cycle_count[31:0] <= access.wdata;
			end else if (wr_csr && wr_index == csr_mcycleh) begin
				cycle_count[63:32] <= access.wdata;
			end else begin
				cycle_count <= cycle_count + 64'd1;
			end

			if (wr_csr && wr_index == csr_minstret) begin
				instr_count[31:0] <= access.wdata;
			end else if (wr_csr && wr_index == csr_minstreth) begin
				instr_count[63:32] <= access.wdata;
			end else if (instr_complete) begin
				instr_count <= instr_count + 64'd1;
			end
		end
	end

	// Trap setup and status
	always_ff @(posedge clock) begin
		if (reset) begin
			mtvec <= '0;
			mscratch <= '0;
			mcause_int <= 1'b0;
			mcause_code <= 4'd0;
			meie <= 1'b1;
			mie <= 1'b1;
			mpie <= 1'b0;
		end else begin
			if (trap) begin
				mpie <= mie;
				mie <= 1'b0;
			end
			// Return takes priority when both arrive together
			if (tret) begin
				mie <= mpie;
				mpie <= 1'b0;
			end
			// Software write to mstatus beats both
			if (wr_csr && wr_index == csr_mstatus) begin
				mie <= access.wdata[3];
				mpie <= access.wdata[7];
			end

			if (wr_csr && wr_index == csr_mie) begin
				meie <= access.wdata[11];
			end
			if (wr_csr && wr_index == csr_mtvec) begin
				mtvec <= access.wdata;
			end
			if (wr_csr && wr_index == csr_mscratch) begin
				mscratch <= access.wdata;
			end
			if (wr_csr && wr_index == csr_mcause) begin
				mcause_int <= access.wdata[31];
				mcause_code <= access.wdata[3:0];
			end
		end
	end

	// Readout layout, shared by both ports
	function automatic word_t csr_read(input csr_index_t index);
		word_t data;
		data = '0;
		case (index)
			csr_mstatus: data = {24'd0, mpie, 3'd0, mie, 3'd0};
			csr_misa: data = {2'b01, `REGFILE_ISA};
			csr_mie: data = {20'd0, meie, 11'd0};
			csr_mtvec: data = mtvec;
			csr_mscratch: data = mscratch;
			csr_mcause: data = {mcause_int, 27'd0, mcause_code};
			csr_mip: data = {20'd0, irq, 11'd0};
			csr_mcycle: data = counters_on ? cycle_count[31:0] : '0;
			csr_mcycleh: data = counters_on ? cycle_count[63:32] : '0;
			csr_minstret: data = counters_on ? instr_count[31:0] : '0;
			csr_minstreth: data = counters_on ? instr_count[63:32] : '0;
			csr_mvendorid: data = `REGFILE_VENDORID;
			csr_marchid: data = `REGFILE_ARCHID;
			csr_mimpid: data = `REGFILE_IMPID;
			csr_mhartid: data = `REGFILE_HARTID;
			default: data = '0;
		endcase
		return data;
	endfunction

	always_ff @(posedge clock) begin
		ra_csr <= csr_read(access.ra_addr[4:0]);
		rb_csr <= csr_read(access.rb_addr[4:0]);
	end

endmodule

// ==== hdl/read_select.sv ====
/*
 * Read-port combiner: registers the class of each read address along
 * with the bank data, then picks zero, general or control data.
 */
`timescale 1ns/1ns

module read_select (
	input logic clock,
	input regfile_pkg::reg_addr_t ra_addr,
	input regfile_pkg::reg_addr_t rb_addr,
	input regfile_pkg::word_t ra_gpr,
	input regfile_pkg::word_t rb_gpr,
	input regfile_pkg::word_t ra_csr,
	input regfile_pkg::word_t rb_csr,
	output regfile_pkg::word_t ra_data,
	output regfile_pkg::word_t rb_data
);
	import regfile_pkg::*;

	// Address classes
	localparam logic [1:0] class_zero = 2'd0;
	localparam logic [1:0] class_gpr = 2'd1;
	localparam logic [1:0] class_csr = 2'd2;

	logic [1:0] ra_class;
	logic [1:0] rb_class;

	function automatic logic [1:0] addr_class(input reg_addr_t addr);
		if (addr[5]) begin
			return class_csr;
		end
		return (addr[4:0] == 5'd0) ? class_zero : class_gpr;
	endfunction

	function automatic word_t pick(input logic [1:0] cls, input word_t gpr, input word_t csr);
		case (cls)
			class_gpr: return gpr;
			class_csr: return csr;
			default: return '0;
		endcase
	endfunction

	// Same edge as the banks register their data
	always_ff @(posedge clock) begin
		ra_class <= addr_class(ra_addr);
		rb_class <= addr_class(rb_addr);
	end

	assign ra_data = pick(ra_class, ra_gpr, ra_csr);
	assign rb_data = pick(rb_class, rb_gpr, rb_csr);

endmodule

// ==== hdl/regfile_top.sv ====
/*
 * Register file top level: general and control banks behind one 6-bit
 * address space, one write port and two read ports with one cycle of
 * read latency. No stalls, every access is taken in every cycle.
 */
`timescale 1ns/1ns

module regfile_top (
	input logic clock,
	input logic reset,
	input logic wen,
	input regfile_pkg::reg_addr_t waddr,
	input regfile_pkg::word_t wdata,
	input regfile_pkg::reg_addr_t ra_addr,
	input regfile_pkg::reg_addr_t rb_addr,
	input logic instr_complete,
	input logic trap,
	input logic tret,
	input logic irq,
	output regfile_pkg::word_t ra_data,
	output regfile_pkg::word_t rb_data,
	output logic soft_reset_req,
	output regfile_pkg::word_t mtvec,
	output logic meie,
	output logic mie
);
	import regfile_pkg::*;

	reg_access_if access ();

	// Source side of the access bundle
	assign access.wen = wen;
	assign access.waddr = waddr;
	assign access.wdata = wdata;
	assign access.ra_addr = ra_addr;
	assign access.rb_addr = rb_addr;

	word_t ra_gpr;
	word_t rb_gpr;
	word_t ra_csr;
	word_t rb_csr;

	gpr_bank u_gpr_bank (
		.clock (clock),
		.access (access.bank),
		.ra_gpr (ra_gpr),
		.rb_gpr (rb_gpr)
	);

	csr_bank u_csr_bank (
		.clock (clock),
		.reset (reset),
		.access (access.bank),
		.instr_complete (instr_complete),
		.trap (trap),
		.tret (tret),
		.irq (irq),
		.ra_csr (ra_csr),
		.rb_csr (rb_csr),
		.soft_reset_req (soft_reset_req),
		.mtvec (mtvec),
		.meie (meie),
		.mie (mie)
	);

	read_select u_read_select (
		.clock (clock),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.ra_gpr (ra_gpr),
		.rb_gpr (rb_gpr),
		.ra_csr (ra_csr),
		.rb_csr (rb_csr),
		.ra_data (ra_data),
		.rb_data (rb_data)
	);

endmodule

// ==== verification/regfile_tb.sv ====
/*
 * Testbench for the register file. Drives random and directed traffic on
 * the falling edge, keeps a shadow of all register state updated at each
 * rising edge, and compares both read ports one cycle after each address.
 */
`timescale 1ns/1ns

`include "regfile_config.svh"

module regfile_tb;
	import regfile_pkg::*;

	logic clock;
	logic reset;
	logic wen;
	reg_addr_t waddr;
	word_t wdata;
	reg_addr_t ra_addr;
	reg_addr_t rb_addr;
	logic instr_complete;
	logic trap;
	logic tret;
	logic irq;
	word_t ra_data;
	word_t rb_data;
	logic soft_reset_req;
	word_t mtvec;
	logic meie;
	logic mie;

	// Shadow of the DUT state
	word_t gpr_shadow [1:31];
	logic [63:0] sh_cycle;
	logic [63:0] sh_instret;
	word_t sh_mtvec;
	word_t sh_mscratch;
	word_t sh_mcause;
	logic sh_mie;
	logic sh_mpie;
	logic sh_meie;

	// Expected read data captured at the last rising edge
	word_t exp_a;
	word_t exp_b;
	logic exp_valid;
	int error_count;

	csr_index_t writable [5] = '{csr_mtvec, csr_mscratch, csr_mcause, csr_mstatus, csr_mie};
	csr_index_t read_only [6] = '{csr_misa, csr_mip, csr_mvendorid, csr_marchid,
		csr_mimpid, csr_mhartid};

	regfile_top UUT (
		.clock (clock),
		.reset (reset),
		.wen (wen),
		.waddr (waddr),
		.wdata (wdata),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.instr_complete (instr_complete),
		.trap (trap),
		.tret (tret),
		.irq (irq),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.soft_reset_req (soft_reset_req),
		.mtvec (mtvec),
		.meie (meie),
		.mie (mie)
	);

	always begin
		clock = 1'b0;
		#50;
		clock = 1'b1;
		#50;
	end

	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

	task stop_on_error;
		error_count++;
		$display("Errors found");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task check_value(input string name, input word_t actual, input word_t expected);
		assert (actual === expected) else begin
			$display("** Error: %s = %h, expected %h", name, actual, expected);
			stop_on_error();
		end
	endtask

	function automatic reg_addr_t csr_addr(input csr_index_t index);
		return {1'b1, index};
	endfunction

	// Expected word for a read address, from the shadow state
	function automatic word_t model_read(input reg_addr_t addr);
		word_t value;
		logic counters_on;
		value = '0;
		counters_on = (`REGFILE_ENABLE_COUNTERS != 0);
		if (!addr[5]) begin
			if (addr[4:0] != 5'd0) begin
				value = gpr_shadow[addr[4:0]];
			end
		end else begin
			case (addr[4:0])
				csr_mstatus: value = (word_t'(sh_mpie) << 7) | (word_t'(sh_mie) << 3);
				csr_misa: value = {2'b01, `REGFILE_ISA};
				csr_mie: value = word_t'(sh_meie) << 11;
				csr_mtvec: value = sh_mtvec;
				csr_mscratch: value = sh_mscratch;
				csr_mcause: value = sh_mcause;
				csr_mip: value = word_t'(irq) << 11;
				csr_mcycle: value = counters_on ? sh_cycle[31:0] : 32'd0;
				csr_mcycleh: value = counters_on ? sh_cycle[63:32] : 32'd0;
				csr_minstret: value = counters_on ? sh_instret[31:0] : 32'd0;
				csr_minstreth: value = counters_on ? sh_instret[63:32] : 32'd0;
				csr_mvendorid: value = `REGFILE_VENDORID;
				csr_marchid: value = `REGFILE_ARCHID;
				csr_mimpid: value = `REGFILE_IMPID;
				csr_mhartid: value = `REGFILE_HARTID;
				default: value = '0;
			endcase
		end
		return value;
	endfunction

	task automatic update_shadow;
		logic wr_csr;
		csr_index_t index;
		logic next_mie;
		logic next_mpie;
		wr_csr = wen && waddr[5];
		index = waddr[4:0];
		if (wen && !waddr[5] && index != 5'd0) begin
			gpr_shadow[index] = wdata;
		end
		// A half write takes the place of the count at this edge
		if (wr_csr && index == csr_mcycle) begin
			sh_cycle[31:0] = wdata;
		end else if (wr_csr && index == csr_mcycleh) begin
			sh_cycle[63:32] = wdata;
		end else begin
			sh_cycle = sh_cycle + 64'd1;
		end
		if (wr_csr && index == csr_minstret) begin
			sh_instret[31:0] = wdata;
		end else if (wr_csr && index == csr_minstreth) begin
			sh_instret[63:32] = wdata;
		end else if (instr_complete) begin
			sh_instret = sh_instret + 64'd1;
		end
		next_mie = sh_mie;
		next_mpie = sh_mpie;
		if (trap) begin
			next_mpie = sh_mie;
			next_mie = 1'b0;
		end
		if (tret) begin
			next_mie = sh_mpie;
			next_mpie = 1'b0;
		end
		if (wr_csr && index == csr_mstatus) begin
			next_mie = wdata[3];
			next_mpie = wdata[7];
		end
		sh_mie = next_mie;
		sh_mpie = next_mpie;
		if (wr_csr && index == csr_mie) begin
			sh_meie = wdata[11];
		end
		if (wr_csr && index == csr_mtvec) begin
			sh_mtvec = wdata;
		end
		if (wr_csr && index == csr_mscratch) begin
			sh_mscratch = wdata;
		end
		if (wr_csr && index == csr_mcause) begin
			sh_mcause = wdata & 32'h8000_000f;
		end
	endtask

	// Rising edge: soft reset check, expected read data, then state update
	always @(posedge clock) begin
		check_value("soft_reset_req", soft_reset_req,
			word_t'(wen && waddr == csr_addr(csr_soft_reset)));
		exp_a = model_read(ra_addr);
		exp_b = model_read(rb_addr);
		if (reset) begin
			sh_cycle = '0;
			sh_instret = '0;
			sh_mtvec = '0;
			sh_mscratch = '0;
			sh_mcause = '0;
			sh_mie = 1'b1;
			sh_mpie = 1'b0;
			sh_meie = 1'b1;
			exp_valid = 1'b0;
		end else begin
			update_shadow();
			exp_valid = 1'b1;
		end
	end

	// Comparing process, outputs are stable at the falling edge
	always @(negedge clock) begin
		if (exp_valid) begin
			check_value("ra_data", ra_data, exp_a);
			check_value("rb_data", rb_data, exp_b);
			check_value("mtvec", mtvec, sh_mtvec);
			check_value("mie", word_t'(mie), word_t'(sh_mie));
			check_value("meie", word_t'(meie), word_t'(sh_meie));
		end
	end

	task set_idle;
		wen = 1'b0;
		trap = 1'b0;
		tret = 1'b0;
		instr_complete = 1'b0;
	endtask

	task wait_reset_release;
		int cycles;
		cycles = 0;
		while (reset !== 1'b0) begin
			@(posedge clock);
			cycles++;
			if (cycles > 100) begin
				$display("Timeout: reset was never released");
				stop_on_error();
			end
		end
	endtask

	initial begin : stimulus
		int i;
		reg_addr_t last_waddr;
		void'($urandom(6278));
		error_count = 0;
		exp_valid = 1'b0;
		set_idle();
		waddr = '0;
		wdata = '0;
		ra_addr = '0;
		rb_addr = '0;
		irq = 1'b0;
		wait_reset_release();

		// Reset values
		@(negedge clock);
		ra_addr = csr_addr(csr_mstatus);
		rb_addr = csr_addr(csr_mtvec);
		@(negedge clock);
		check_value("ra_data", ra_data, 32'h0000_0008);
		check_value("rb_data", rb_data, 32'h0000_0000);
		check_value("mie", word_t'(mie), 32'd1);
		check_value("meie", word_t'(meie), 32'd1);
		ra_addr = csr_addr(csr_mscratch);
		rb_addr = csr_addr(csr_mcause);
		@(negedge clock);
		check_value("ra_data", ra_data, 32'h0000_0000);
		check_value("rb_data", rb_data, 32'h0000_0000);

		// Fill x1 to x31 so every general read has a known value
		for (i = 1; i < 32; i++) begin
			@(negedge clock);
			set_idle();
			wen = 1'b1;
			waddr = reg_addr_t'(i);
			wdata = $urandom();
			ra_addr = '0;
			rb_addr = '0;
		end

		// Random traffic over the whole space, port B follows the last write
		last_waddr = '0;
		for (i = 0; i < 500; i++) begin
			@(negedge clock);
			set_idle();
			wen = $urandom_range(0, 1);
			waddr = $urandom_range(0, 63);
			wdata = $urandom();
			irq = $urandom_range(0, 1);
			instr_complete = $urandom_range(0, 1);
			ra_addr = ($urandom_range(0, 3) == 0) ? waddr : reg_addr_t'($urandom_range(0, 63));
			rb_addr = last_waddr;
			last_waddr = waddr;
		end

		// Control registers, writable and read-only
		for (i = 0; i < 120; i++) begin
			@(negedge clock);
			set_idle();
			irq = $urandom_range(0, 1);
			wen = 1'b1;
			wdata = $urandom();
			case ($urandom_range(0, 2))
				0: waddr = csr_addr(writable[$urandom_range(0, 4)]);
				1: waddr = csr_addr(read_only[$urandom_range(0, 5)]);
				default: wen = 1'b0;
			endcase
			ra_addr = last_waddr;
			rb_addr = (i % 2 == 0) ? csr_addr(csr_mip) : csr_addr($urandom_range(0, 31));
			last_waddr = waddr;
		end

		// Counters close to a carry into the high halves
		@(negedge clock);
		set_idle();
		wen = 1'b1;
		waddr = csr_addr(csr_minstret);
		wdata = 32'hffff_fff8;
		@(negedge clock);
		waddr = csr_addr(csr_minstreth);
		wdata = 32'h0000_0000;
		@(negedge clock);
		waddr = csr_addr(csr_mcycle);
		wdata = 32'hffff_ffe0;
		@(negedge clock);
		waddr = csr_addr(csr_mcycleh);
		wdata = 32'h0000_0001;
		for (i = 0; i < 120; i++) begin
			@(negedge clock);
			set_idle();
			instr_complete = $urandom_range(0, 1);
			ra_addr = (i % 2 == 0) ? csr_addr(csr_minstret) : csr_addr(csr_mcycle);
			rb_addr = (i % 2 == 0) ? csr_addr(csr_minstreth) : csr_addr(csr_mcycleh);
		end

		// Trap entry and return, sometimes both, sometimes with an mstatus write
		for (i = 0; i < 200; i++) begin
			@(negedge clock);
			set_idle();
			trap = ($urandom_range(0, 2) == 0);
			tret = ($urandom_range(0, 2) == 0);
			wen = ($urandom_range(0, 7) == 0);
			waddr = csr_addr(csr_mstatus);
			wdata = $urandom();
			ra_addr = csr_addr(csr_mstatus);
			rb_addr = csr_addr(csr_mstatus);
		end

		// Soft reset index against neighbours and x15
		for (i = 0; i < 80; i++) begin
			@(negedge clock);
			set_idle();
			wen = $urandom_range(0, 1);
			wdata = $urandom();
			case ($urandom_range(0, 2))
				0: waddr = csr_addr(csr_soft_reset);
				1: waddr = {1'b0, csr_soft_reset};
				default: waddr = csr_addr($urandom_range(0, 31));
			endcase
			ra_addr = $urandom_range(0, 63);
			rb_addr = csr_addr(csr_soft_reset);
		end

		@(negedge clock);
		set_idle();
		repeat (2) @(negedge clock);
		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+hdl
hdl/regfile_pkg.sv
hdl/reg_access_if.sv
hdl/gpr_bank.sv
hdl/csr_bank.sv
hdl/read_select.sv
hdl/regfile_top.sv
verification/regfile_tb.sv
